// ==== src/icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// byte address from the fetch stage
`define ADDR_WIDTH 32

// one fetch word
`define XLEN 64

// sets per way
`define SET_COUNT 64

// words per line, also the refill burst length
`define LINE_WORDS 4

// top nibble of addresses that bypass the arrays
`define UNCACHED_NIBBLE 4'b0011

`endif

// ==== src/icachePkg.sv ====
`include "icache_settings.svh"

package icachePkg;

    // address split: tag | index | word | byte
    localparam int byteBits = $clog2(`XLEN / 8);
    localparam int wordBits = $clog2(`LINE_WORDS);
    localparam int offsetBits = byteBits + wordBits;
    localparam int indexBits = $clog2(`SET_COUNT);
    localparam int tagBits = `ADDR_WIDTH - indexBits - offsetBits;

    typedef enum logic [2:0] {
        idle    = 3'b000,
        compare = 3'b001,
        miss    = 3'b010,
        getData = 3'b011,
        replace = 3'b111
    } ctrlState_e;

    typedef logic [tagBits-1:0] tag_t;
    typedef logic [indexBits-1:0] index_t;
    typedef logic [wordBits-1:0] wordSel_t;
    // word 0 sits in the low bits
    typedef logic [`LINE_WORDS-1:0][`XLEN-1:0] line_t;

endpackage

// ==== src/cacheWay.sv ====
`include "icache_settings.svh"

module cacheWay (
    input  logic                 clk,
    input  logic                 rst_n,
    input  icachePkg::index_t    lookupIndex_i,
    input  icachePkg::tag_t      lookupTag_i,
    input  icachePkg::wordSel_t  wordSel_i,
    input  logic                 we_i,
    input  icachePkg::line_t     fillLine_i,
    output logic                 hit_o,
    output logic [`XLEN-1:0]     word_o
);

    // tag and line storage, read synchronously
    icachePkg::tag_t tagMem [`SET_COUNT];
    icachePkg::line_t lineMem [`SET_COUNT];

    // one valid bit per set
    logic [`SET_COUNT-1:0] validBits;

    // read results, one cycle after the index was presented
    icachePkg::tag_t readTag;
    icachePkg::line_t readLine;
    logic readValid;

    // arrays
    // a write in the same cycle returns the old contents
    always_ff @(posedge clk) begin
        if (we_i) begin
            tagMem[lookupIndex_i] <= lookupTag_i;
            lineMem[lookupIndex_i] <= fillLine_i;
        end
        readTag <= tagMem[lookupIndex_i];
        readLine <= lineMem[lookupIndex_i];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            validBits <= '0;
            readValid <= 1'b0;
        end else begin
            if (we_i) begin
                validBits[lookupIndex_i] <= 1'b1;
            end
            readValid <= validBits[lookupIndex_i];
        end
    end

    // tag in lookupTag_i belongs to the request that was read last cycle
    assign hit_o = readValid && (readTag == lookupTag_i);

    assign word_o = readLine[wordSel_i];

endmodule

// ==== src/hitMerge.sv ====
`include "icache_settings.svh"

module hitMerge (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`XLEN-1:0]     memData_i,
    input  logic                 memValid_i,
    input  logic                 memLast_i,
    input  logic                 hit0_i,
    input  logic                 hit1_i,
    input  logic [`XLEN-1:0]     word0_i,
    input  logic [`XLEN-1:0]     word1_i,
    input  icachePkg::wordSel_t  wordSel_i,
    input  logic                 uncached_i,
    input  logic                 bufferSel_i,
    output icachePkg::line_t     fillLine_o,
    output logic [`XLEN-1:0]     rdData_o,
    output logic                 anyHit_o
);

    icachePkg::wordSel_t beatCnt;
    icachePkg::line_t fillBuf;

    // beat position within the burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beatCnt <= '0;
        end else if (memValid_i) begin
            beatCnt <= memLast_i ? '0 : beatCnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (memValid_i) begin
            fillBuf[beatCnt] <= memData_i;
        end
    end

    assign fillLine_o = fillBuf;

    // buffered line wins while the arrays catch up
    always_comb begin
        if (bufferSel_i) begin
            rdData_o = uncached_i ? fillBuf[0] : fillBuf[wordSel_i];
        end else if (hit1_i) begin
            rdData_o = word1_i;
        end else begin
            rdData_o = word0_i;
        end
    end

    // uncached lines are never in the ways
    assign anyHit_o = bufferSel_i || ((hit0_i || hit1_i) && !uncached_i);

endmodule

// ==== src/icacheCtrl.sv ====
`include "icache_settings.svh"

module icacheCtrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_i,
    input  logic [`ADDR_WIDTH-1:0]  addr_i,
    input  logic                    stall_n,
    input  logic                    memReady_i,
    input  logic                    memValid_i,
    input  logic                    memLast_i,
    input  logic                    anyHit_i,
    output logic                    addrOk_o,
    output logic                    dataOk_o,
    output logic                    dataNotOk_o,
    output logic                    memReq_o,
    output logic [`ADDR_WIDTH-1:0]  memAddr_o,
    output logic [1:0]              memLen_o,
    output icachePkg::index_t       lookupIndex_o,
    output icachePkg::tag_t         lookupTag_o,
    output icachePkg::wordSel_t     wordSel_o,
    output logic [1:0]              wayWe_o,
    output logic                    uncached_o,
    output logic                    bufferSel_o
);

    icachePkg::ctrlState_e curState;
    icachePkg::ctrlState_e nextState;
    logic [`ADDR_WIDTH-1:0] reqLatch;
    logic idleSt;
    logic compareSt;
    logic missSt;
    logic getDataSt;
    logic replaceSt;
    logic accept;
    logic lastBeat;
    logic victim;
    logic fillPending;
    logic uncachedOk;

    assign idleSt = curState == icachePkg::idle;
    assign compareSt = curState == icachePkg::compare;
    assign missSt = curState == icachePkg::miss;
    assign getDataSt = curState == icachePkg::getData;
    assign replaceSt = curState == icachePkg::replace;

    // a new address is taken only when the current one is answered
    assign addrOk_o = idleSt || (compareSt && anyHit_i);
    assign accept = valid_i && addrOk_o && stall_n;
    assign lastBeat = getDataSt && memValid_i && memLast_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curState <= icachePkg::idle;
        end else begin
            curState <= nextState;
        end
    end

    always_comb begin
        nextState = curState;
        case (curState)
            icachePkg::idle: begin
                if (accept) begin
                    nextState = icachePkg::compare;
                end
            end
            icachePkg::compare: begin
                // stalled hits stay here and keep their result
                if (!anyHit_i) begin
                    nextState = icachePkg::miss;
                end else if (!accept && stall_n) begin
                    nextState = icachePkg::idle;
                end
            end
            icachePkg::miss: begin
                if (memReady_i) begin
                    nextState = icachePkg::getData;
                end
            end
            icachePkg::getData: begin
                if (lastBeat) begin
                    nextState = uncached_o ? icachePkg::compare : icachePkg::replace;
                end
            end
            icachePkg::replace: begin
                nextState = icachePkg::compare;
            end
            default: begin
                nextState = icachePkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reqLatch <= '0;
        end else if (accept) begin
            reqLatch <= addr_i;
        end
    end

    assign uncached_o = reqLatch[`ADDR_WIDTH-1 -: 4] == `UNCACHED_NIBBLE;

    // live index on acceptance so the synchronous read lands in compare
    assign lookupIndex_o = accept ? addr_i[icachePkg::offsetBits +: icachePkg::indexBits]
                                  : reqLatch[icachePkg::offsetBits +: icachePkg::indexBits];
    assign lookupTag_o = reqLatch[`ADDR_WIDTH-1 -: icachePkg::tagBits];
    assign wordSel_o = reqLatch[icachePkg::byteBits +: icachePkg::wordBits];

    assign dataOk_o = compareSt && anyHit_i;
    assign dataNotOk_o = (compareSt && !anyHit_i) || missSt || getDataSt || replaceSt;

    // memory request, whole line or the single uncached word
    assign memReq_o = missSt && memReady_i;
    assign memAddr_o = uncached_o ? reqLatch
                                  : {reqLatch[`ADDR_WIDTH-1:icachePkg::offsetBits],
                                     {icachePkg::offsetBits{1'b0}}};
    assign memLen_o = uncached_o ? 2'd0 : 2'(`LINE_WORDS - 1);

    assign wayWe_o[0] = replaceSt && !victim;
    assign wayWe_o[1] = replaceSt && victim;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim <= 1'b0;
            fillPending <= 1'b0;
            uncachedOk <= 1'b0;
        end else begin
            if (replaceSt) begin
                victim <= ~victim;
            end
            fillPending <= getDataSt || replaceSt;
            // uncached word lives only in the buffer, hold it through a stall
            if (lastBeat && uncached_o) begin
                uncachedOk <= 1'b1;
            end else if (!(compareSt && !stall_n)) begin
                uncachedOk <= 1'b0;
            end
        end
    end

    assign bufferSel_o = fillPending || uncachedOk;

endmodule

// ==== src/icacheTop.sv ====
`include "icache_settings.svh"

module icacheTop (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_i,
    input  logic [`ADDR_WIDTH-1:0]  addr_i,
    input  logic                    stall_n,
    output logic                    addrOk_o,
    output logic                    dataOk_o,
    output logic                    dataNotOk_o,
    output logic [`XLEN-1:0]        rdData_o,
    output logic                    memReq_o,
    input  logic                    memReady_i,
    output logic [`ADDR_WIDTH-1:0]  memAddr_o,
    output logic [1:0]              memLen_o,
    input  logic [`XLEN-1:0]        memData_i,
    input  logic                    memValid_i,
    input  logic                    memLast_i
);

    icachePkg::index_t lookupIndex;
    icachePkg::tag_t lookupTag;
    icachePkg::wordSel_t wordSel;
    icachePkg::line_t fillLine;
    logic [1:0] wayWe;
    logic [1:0] wayHit;
    logic [`XLEN-1:0] wayWord [2];
    logic uncached;
    logic bufferSel;
    logic anyHit;

    icacheCtrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid_i),
        .addr_i        (addr_i),
        .stall_n       (stall_n),
        .memReady_i    (memReady_i),
        .memValid_i    (memValid_i),
        .memLast_i     (memLast_i),
        .anyHit_i      (anyHit),
        .addrOk_o      (addrOk_o),
        .dataOk_o      (dataOk_o),
        .dataNotOk_o   (dataNotOk_o),
        .memReq_o      (memReq_o),
        .memAddr_o     (memAddr_o),
        .memLen_o      (memLen_o),
        .lookupIndex_o (lookupIndex),
        .lookupTag_o   (lookupTag),
        .wordSel_o     (wordSel),
        .wayWe_o       (wayWe),
        .uncached_o    (uncached),
        .bufferSel_o   (bufferSel)
    );

    // two identical ways, each with its own write enable
    for (genvar w = 0; w < 2; w++) begin : g_way
        cacheWay u_way (
            .clk           (clk),
            .rst_n         (rst_n),
            .lookupIndex_i (lookupIndex),
            .lookupTag_i   (lookupTag),
            .wordSel_i     (wordSel),
            .we_i          (wayWe[w]),
            .fillLine_i    (fillLine),
            .hit_o         (wayHit[w]),
            .word_o        (wayWord[w])
        );
    end

    hitMerge u_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .memData_i   (memData_i),
        .memValid_i  (memValid_i),
        .memLast_i   (memLast_i),
        .hit0_i      (wayHit[0]),
        .hit1_i      (wayHit[1]),
        .word0_i     (wayWord[0]),
        .word1_i     (wayWord[1]),
        .wordSel_i   (wordSel),
        .uncached_i  (uncached),
        .bufferSel_i (bufferSel),
        .fillLine_o  (fillLine),
        .rdData_o    (rdData_o),
        .anyHit_o    (anyHit)
    );

endmodule

// ==== bench/memModel.sv ====
`include "icache_settings.svh"

module memModel (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [3:0]              maxDelay_i,
    input  logic                    memReq_i,
    input  logic [`ADDR_WIDTH-1:0]  memAddr_i,
    input  logic [1:0]              memLen_i,
    output logic                    memReady_o,
    output logic [`XLEN-1:0]        memData_o,
    output logic                    memValid_o,
    output logic                    memLast_o
);

    logic taken;
    logic [`ADDR_WIDTH-1:0] takenAddr;
    logic [1:0] takenLen;

    // fill pattern, every address bit matters
    function automatic logic [`XLEN-1:0] beatData(input logic [`ADDR_WIDTH-1:0] a);
        beatData = {a ^ 32'h6C8E_9CF5, {a[15:0], a[31:16]} + 32'h0F0F_3C3C};
    endfunction

    // request pulse sampled at the rising edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taken <= 1'b0;
        end else begin
            taken <= memReq_i && memReady_o;
            if (memReq_i && memReady_o) begin
                takenAddr <= memAddr_i;
                takenLen <= memLen_i;
            end
        end
    end

    // all outputs move on falling edges
    initial begin
        int unsigned waitCycles;
        int unsigned gap;
        memReady_o = 1'b0;
        memValid_o = 1'b0;
        memLast_o = 1'b0;
        memData_o = '0;
        wait (rst_n);
        @(negedge clk);
        forever begin
            // ready for one cycle after a random pause
            waitCycles = $urandom_range(maxDelay_i, 0);
            memReady_o = 1'b0;
            repeat (waitCycles) @(negedge clk);
            memReady_o = 1'b1;
            @(negedge clk);
            if (taken) begin
                memReady_o = 1'b0;
                for (int beat = 0; beat <= takenLen; beat++) begin
                    gap = (maxDelay_i == 0) ? 0 : $urandom_range(2, 0);
                    repeat (gap) @(negedge clk);
                    memValid_o = 1'b1;
                    memData_o = beatData(takenAddr + 32'(beat * 8));
                    memLast_o = beat == takenLen;
                    @(negedge clk);
                    memValid_o = 1'b0;
                    memLast_o = 1'b0;
                end
            end
        end
    end

endmodule

// ==== bench/icacheTb.sv ====
`include "icache_settings.svh"

module icacheTb;

    localparam int randomCount = 60;
    localparam int reqTotal = 5 + 7 + 3 + 9 + randomCount;
    localparam int maxDelayLimit = 7;
    localparam int timeoutCycles = 10 * reqTotal * (`LINE_WORDS + maxDelayLimit + 4);

    logic clk = 1'b0;
    logic rst_n;
    logic valid;
    logic [`ADDR_WIDTH-1:0] addr;
    logic stall_n;
    logic addrOk;
    logic dataOk;
    logic dataNotOk;
    logic [`XLEN-1:0] rdData;
    logic memReq;
    logic memReady;
    logic [`ADDR_WIDTH-1:0] memAddr;
    logic [1:0] memLen;
    logic [`XLEN-1:0] memData;
    logic memValid;
    logic memLast;
    logic [3:0] memDelay;

    // expected words and memory requests in arrival order
    logic [`XLEN-1:0] expQ [$];
    logic [`ADDR_WIDTH+1:0] reqQ [$];

    // shadow of the tag arrays
    logic [20:0] tagModel [2][`SET_COUNT];
    logic validModel [2][`SET_COUNT];
    logic victimModel;

    int dataErrors = 0;
    int reqErrors = 0;
    int protoErrors = 0;
    int memReqCount = 0;
    int expReqCount = 0;
    int cycleCount = 0;

    always #50 clk = ~clk;

    icacheTop DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid),
        .addr_i      (addr),
        .stall_n     (stall_n),
        .addrOk_o    (addrOk),
        .dataOk_o    (dataOk),
        .dataNotOk_o (dataNotOk),
        .rdData_o    (rdData),
        .memReq_o    (memReq),
        .memReady_i  (memReady),
        .memAddr_o   (memAddr),
        .memLen_o    (memLen),
        .memData_i   (memData),
        .memValid_i  (memValid),
        .memLast_i   (memLast)
    );

    memModel u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .maxDelay_i (memDelay),
        .memReq_i   (memReq),
        .memAddr_i  (memAddr),
        .memLen_i   (memLen),
        .memReady_o (memReady),
        .memData_o  (memData),
        .memValid_o (memValid),
        .memLast_o  (memLast)
    );

    // memory contents as seen from the fetch stage
    function automatic logic [`XLEN-1:0] expectWord(input logic [`ADDR_WIDTH-1:0] a);
        expectWord = {a ^ 32'h6C8E_9CF5, {a[15:0], a[31:16]} + 32'h0F0F_3C3C};
    endfunction

    // hit or miss from the shadow tags with the victim way toggling per refill
    task automatic predict(input logic [`ADDR_WIDTH-1:0] a, output logic hit);
        logic [5:0] idx;
        logic [20:0] tag;
        idx = a[10:5];
        tag = a[31:11];
        hit = 1'b0;
        if (a[31:28] == `UNCACHED_NIBBLE) begin
            reqQ.push_back({a, 2'd0});
            expReqCount++;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (validModel[w][idx] && tagModel[w][idx] == tag) begin
                    hit = 1'b1;
                end
            end
            if (!hit) begin
                reqQ.push_back({a[31:5], 5'b0, 2'd3});
                expReqCount++;
                tagModel[victimModel][idx] = tag;
                validModel[victimModel][idx] = 1'b1;
                victimModel = ~victimModel;
            end
        end
        expQ.push_back(expectWord(a));
    endtask

    // called on a falling edge and returns in the cycle after acceptance
    task automatic fetch(input logic [`ADDR_WIDTH-1:0] a);
        logic hit;
        valid = 1'b1;
        addr = a;
        stall_n = 1'b1;
        while (!addrOk) begin
            @(negedge clk);
        end
        predict(a, hit);
        @(negedge clk);
        valid = 1'b0;
        if (hit && !dataOk) begin
            protoErrors++;
            $display("hit on %h was not answered in the cycle after acceptance", a);
        end
        if (!hit && !dataNotOk) begin
            protoErrors++;
            $display("miss on %h did not raise dataNotOk_o", a);
        end
        // a hit frees the port at once, a miss keeps it closed
        if (addrOk !== hit) begin
            protoErrors++;
            $display("Fail at %0t: addrOk_o %b after accepting %h, expected %b",
                     $time, addrOk, a, hit);
        end
    endtask

    // hold the pipeline on a hit while offering another address
    task automatic stallDuringHit(input logic [`ADDR_WIDTH-1:0] a,
                                  input logic [`ADDR_WIDTH-1:0] other);
        fetch(a);
        stall_n = 1'b0;
        valid = 1'b1;
        addr = other;
        repeat (3) begin
            @(negedge clk);
            if (!dataOk) begin
                protoErrors++;
                $display("dataOk_o dropped while the pipeline was stalled");
            end
        end
        stall_n = 1'b1;
        valid = 1'b0;
    endtask

    // compare results and memory requests just before each rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (dataOk && dataNotOk) begin
                protoErrors++;
                $display("dataOk_o and dataNotOk_o both high at %0t", $time);
            end
            if (dataOk) begin
                if (expQ.size() == 0) begin
                    protoErrors++;
                    $display("result at %0t with no request outstanding", $time);
                end else begin
                    if (rdData !== expQ[0]) begin
                        dataErrors++;
                        $display("Fail at %0t: rdData_o %h, expected %h",
                                 $time, rdData, expQ[0]);
                    end
                    if (stall_n) begin
                        void'(expQ.pop_front());
                    end
                end
            end
            if (memReq) begin
                memReqCount++;
                if (reqQ.size() == 0) begin
                    reqErrors++;
                    $display("memory request at %0t where the model expects a hit", $time);
                end else begin
                    if ({memAddr, memLen} !== reqQ[0]) begin
                        reqErrors++;
                        $display("Fail at %0t: memory request %h length %0d, %s %h length %0d",
                                 $time, memAddr, memLen, "expected",
                                 reqQ[0][33:2], reqQ[0][1:0]);
                    end
                    void'(reqQ.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", timeoutCycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        logic [`ADDR_WIDTH-1:0] a;
        void'($urandom(68571));
        rst_n = 1'b0;
        valid = 1'b0;
        addr = '0;
        stall_n = 1'b1;
        memDelay = 4'd0;
        victimModel = 1'b0;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < `SET_COUNT; s++) begin
                validModel[w][s] = 1'b0;
                tagModel[w][s] = '0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (dataOk || dataNotOk || memReq) begin
            protoErrors++;
            $display("Fail at %0t: outputs not low after reset", $time);
        end

        // cold miss and then the whole line back to back
        fetch(32'h0000_1048);
        for (int k = 0; k < 4; k++) begin
            fetch(32'h0000_1040 + 32'(k * 8));
        end

        // three tags in set 5
        fetch(32'h0000_08A0);
        fetch(32'h0000_10A8);
        fetch(32'h0000_08B0);
        fetch(32'h0000_10B8);
        fetch(32'h0000_18A0);
        fetch(32'h0000_08A8);
        fetch(32'h0000_10A0);

        // uncached reads where repeats go to memory again
        fetch(32'h3000_0040);
        fetch(32'h3000_0040);
        fetch(32'h3ABC_0128);

        // slow memory with gaps between beats
        memDelay = 4'd5;
        for (int k = 0; k < 6; k++) begin
            fetch(32'h0000_4000 + 32'(k * 32'h820));
        end
        fetch(32'h3000_1000);
        fetch(32'h3000_1008);
        stallDuringHit(32'h0000_4008, 32'h0000_7000);

        // random mix over three sets
        for (int i = 0; i < randomCount; i++) begin
            memDelay = 4'($urandom_range(maxDelayLimit, 0));
            if ($urandom_range(4, 0) == 0) begin
                a = {4'b0011, 25'($urandom), 3'b000};
            end else begin
                a = {21'h100 + 21'($urandom_range(3, 0)), 6'd20 + 6'($urandom_range(2, 0)),
                     2'($urandom_range(3, 0)), 3'b000};
            end
            fetch(a);
        end

        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (reqQ.size() != 0 || memReqCount != expReqCount) begin
            reqErrors++;
            $display("memory saw %0d requests where %0d were expected", memReqCount, expReqCount);
        end

        $display("errors: data %0d, request %0d, protocol %0d (memory requests %0d of %0d)",
                 dataErrors, reqErrors, protoErrors, memReqCount, expReqCount);
        if (dataErrors + reqErrors + protoErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+src
src/icachePkg.sv
src/cacheWay.sv
src/hitMerge.sv
src/icacheCtrl.sv
src/icacheTop.sv
bench/memModel.sv
bench/icacheTb.sv
